// File: ahb2apb_bridge.f
+incdir+include
verilog/ahb2apb_pkg.sv
verilog/ahb_capture.sv
verilog/apb_decoder.sv
verilog/apb_sequencer.sv
verilog/ahb2apb_bridge.sv
sim/ahb2apb_checker.sv
sim/ahb2apb_monitor.sv
sim/ahb2apb_tb.sv

// File: include/ahb2apb_macros.svh
/* Bus widths, slave count, APB address map and AHB transfer type codes
   shared by the bridge RTL and its testbench */

`ifndef AHB2APB_MACROS_SVH
`define AHB2APB_MACROS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AHB2APB_ADDR_W 32
`define AHB2APB_DATA_W 32

// Number of APB slaves behind the bridge
`define AHB2APB_SLAVES 4

// ----------------------------------------
// Address map
// ----------------------------------------
// Slave s owns BASE + s*WINDOW up to BASE + (s+1)*WINDOW - 1
`define AHB2APB_BASE   32'h4000_0000
`define AHB2APB_WINDOW 32'h0000_1000

// ----------------------------------------
// AHB htrans encodings
// ----------------------------------------
`define AHB2APB_HTRANS_NONSEQ 2'b10
`define AHB2APB_HTRANS_SEQ    2'b11

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB to APB bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=ahb2apb_sim

verilator --binary --timing --assert \
  -f ahb2apb_bridge.f \
  --top-module ahb2apb_tb \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation binary exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
  echo "No pass result found in $LOG"
  exit 1
fi

exit 0

// File: sim/ahb2apb_checker.sv
/* APB protocol assertions, bound into the sequencer */

`timescale 1ns/10ps

module ahb2apb_checker (
  input logic                    hclk20,
  input logic                    hreset_n20,
  input ahb2apb_pkg::slave_sel_t psel,
  input ahb2apb_pkg::apb_req_t   apb_cmd
);

  // At most one slave selected
  psel_onehot: assert property (@(posedge hclk20) disable iff (!hreset_n20)
    $onehot0(psel))
    else $error("psel has more than one bit set");

  // First psel cycle is SETUP
  setup_first: assert property (@(posedge hclk20) disable iff (!hreset_n20)
    $rose(psel != '0) |-> !apb_cmd.penable)
    else $error("penable high in the SETUP cycle");

  access_next: assert property (@(posedge hclk20) disable iff (!hreset_n20)
    $rose(psel != '0) |=> apb_cmd.penable)
    else $error("penable did not follow SETUP");

  penable_with_psel: assert property (@(posedge hclk20) disable iff (!hreset_n20)
    apb_cmd.penable |-> (psel != '0) && $past(psel != '0))
    else $error("penable high without a selected slave");

  // Address, direction and select held through ACCESS
  cmd_stable: assert property (@(posedge hclk20) disable iff (!hreset_n20)
    apb_cmd.penable |-> $stable(apb_cmd.paddr) && $stable(apb_cmd.pwrite) && $stable(psel))
    else $error("APB command changed during ACCESS");

endmodule

bind apb_sequencer ahb2apb_checker chk_i (
  .hclk20     (hclk20),
  .hreset_n20 (hreset_n20),
  .psel       (psel),
  .apb_cmd    (apb_cmd)
);

// File: sim/ahb2apb_monitor.sv
/* Bus monitor: shadow memory, reference read model and a compare
   process for every completed transfer */

`timescale 1ns/10ps

`include "ahb2apb_macros.svh"

module ahb2apb_monitor (
  input  logic                    hclk20,
  input  logic                    hreset_n20,
  input  logic                    hsel,
  input  ahb2apb_pkg::addr_t      haddr,
  input  logic [1:0]              htrans,
  input  logic                    hwrite,
  input  ahb2apb_pkg::data_t      hwdata,
  input  logic                    hready,
  input  ahb2apb_pkg::data_t      hrdata,
  input  ahb2apb_pkg::apb_req_t   apb_cmd,
  input  ahb2apb_pkg::slave_sel_t psel,
  input  ahb2apb_pkg::data_t      pwdata,
  input  ahb2apb_pkg::slave_sel_t pready,
  output int                      errors,
  output int                      checked
);

  ahb2apb_pkg::data_t shadow [`AHB2APB_SLAVES][16];
  ahb2apb_pkg::addr_t exp_addr;
  ahb2apb_pkg::data_t wr_data;
  logic               busy = 1'b0;
  logic               exp_write;
  logic               saw_psel;
  int                 low_cycles;
  int                 wait_cycles;
  int                 err_count = 0;
  int                 done_count = 0;

  assign errors  = err_count;
  assign checked = done_count;

  function automatic int slave_of(input ahb2apb_pkg::addr_t a);
    return int'((a - `AHB2APB_BASE) / `AHB2APB_WINDOW);
  endfunction

  // Expected read word for a mapped address
  function automatic ahb2apb_pkg::data_t expected_read(input ahb2apb_pkg::addr_t a);
    return shadow[slave_of(a)][a[5:2]];
  endfunction

  // Sampled mid-cycle, away from the driving edge
  always @(negedge hclk20) begin
    if (!hreset_n20) begin
      busy = 1'b0;
      for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
        for (int i = 0; i < 16; i++) begin
          shadow[s][i] = ahb2apb_pkg::addr_t'(`AHB2APB_BASE + s * `AHB2APB_WINDOW + i * 4)
                         ^ 32'h5A5A_0000;
        end
      end
      if (!hready || psel != '0 || apb_cmd.penable) begin
        $display("FAILED at %0t: reset state hready=%b psel=%b penable=%b",
                 $time, hready, psel, apb_cmd.penable);
        err_count++;
      end
    end else begin
      if (busy && !hready) begin
        low_cycles++;
        if (psel != '0) begin
          saw_psel = 1'b1;
          if (psel != ahb2apb_pkg::slave_sel_t'(1 << slave_of(exp_addr)) ||
              apb_cmd.paddr != exp_addr || apb_cmd.pwrite != exp_write) begin
            $display("FAILED at %0t: psel=%b paddr=0x%08h pwrite=%b for 0x%08h",
                     $time, psel, apb_cmd.paddr, apb_cmd.pwrite, exp_addr);
            err_count++;
          end
        end
        if (apb_cmd.penable && (psel & pready) == '0) begin
          wait_cycles++;
        end else if (apb_cmd.penable) begin
          wr_data = hwdata;
          if (exp_write && pwdata !== wr_data) begin
            $display("FAILED at %0t: pwdata=0x%08h for write 0x%08h, expected 0x%08h",
                     $time, pwdata, exp_addr, wr_data);
            err_count++;
          end
        end
      end else if (busy) begin
        // hready high again, transfer done
        if (!saw_psel || low_cycles != 3 + wait_cycles) begin
          $display("FAILED at %0t: hready low %0d cycles with %0d wait states",
                   $time, low_cycles, wait_cycles);
          err_count++;
        end
        if (exp_write) begin
          shadow[slave_of(exp_addr)][exp_addr[5:2]] = wr_data;
        end else if (hrdata !== expected_read(exp_addr)) begin
          $display("FAILED at %0t: read 0x%08h gave 0x%08h, expected 0x%08h",
                   $time, exp_addr, hrdata, expected_read(exp_addr));
          err_count++;
        end
        done_count++;
        busy = 1'b0;
      end
      if (!busy && hready && hsel &&
          (htrans == `AHB2APB_HTRANS_NONSEQ || htrans == `AHB2APB_HTRANS_SEQ)) begin
        busy        = 1'b1;
        exp_addr    = haddr;
        exp_write   = hwrite;
        saw_psel    = 1'b0;
        low_cycles  = 0;
        wait_cycles = 0;
      end
    end
  end

endmodule

// File: sim/ahb2apb_tb.sv
/* Testbench top: clock and reset, random AHB transfers, APB slave
   memory models with random wait states, timeout and final result */

`timescale 1ns/10ps

`include "ahb2apb_macros.svh"

module ahb2apb_tb;

  localparam int          RESET_CYCLES   = 10;
  localparam int          N_TRANSFERS    = 200;
  localparam int          WORDS          = 16;
  // 8 cycles per transfer at three wait states, then reset and run-in
  localparam int          TIMEOUT_CYCLES = N_TRANSFERS * 8 + 2 * RESET_CYCLES;
  localparam logic [31:0] SEED           = 32'd72111;

  logic                     hclk20 = 1'b0;
  logic                     hreset_n20;
  logic                     hsel;
  ahb2apb_pkg::addr_t       haddr;
  logic [1:0]               htrans;
  logic                     hwrite;
  ahb2apb_pkg::data_t       hwdata;
  logic                     hready;
  ahb2apb_pkg::data_t       hrdata;
  ahb2apb_pkg::apb_req_t    apb_cmd;
  ahb2apb_pkg::slave_sel_t  psel;
  ahb2apb_pkg::data_t       pwdata;
  ahb2apb_pkg::slave_sel_t  pready = '0;
  ahb2apb_pkg::slave_data_t prdata = '0;

  ahb2apb_pkg::data_t mem [`AHB2APB_SLAVES][WORDS];
  // Separate stream for wait states
  logic [31:0]        wait_rng    = SEED ^ 32'h9E37_79B9;
  int                 waits_left  = 0;
  int                 cycle_count = 0;
  int                 errors;
  int                 checked;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic ahb2apb_pkg::addr_t word_addr(input int s, input int i);
    return ahb2apb_pkg::addr_t'(`AHB2APB_BASE + s * `AHB2APB_WINDOW + i * 4);
  endfunction

  always #50 hclk20 = ~hclk20;

  ahb2apb_bridge dut_i (
    .hclk20     (hclk20),
    .hreset_n20 (hreset_n20),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .apb_cmd    (apb_cmd),
    .psel       (psel),
    .pwdata     (pwdata),
    .pready     (pready),
    .prdata     (prdata)
  );

  ahb2apb_monitor mon_i (
    .hclk20     (hclk20),
    .hreset_n20 (hreset_n20),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .apb_cmd    (apb_cmd),
    .psel       (psel),
    .pwdata     (pwdata),
    .pready     (pready),
    .errors     (errors),
    .checked    (checked)
  );

  // ----------------------------------------
  // APB slave memories
  // ----------------------------------------
  // Wait count drawn at the SETUP edge, pready raised once it runs out
  always @(posedge hclk20) begin
    if (!hreset_n20) begin
      for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
        for (int i = 0; i < WORDS; i++) begin
          mem[s][i] <= word_addr(s, i) ^ 32'h5A5A_0000;
        end
      end
      pready <= '0;
    end else begin
      for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
        prdata[s] <= mem[s][apb_cmd.paddr[5:2]];
      end
      if (psel != '0 && !apb_cmd.penable) begin
        wait_rng   = xorshift32(wait_rng);
        waits_left = int'(wait_rng[1:0]);
        pready <= (wait_rng[1:0] == 2'd0) ? psel : '0;
      end else if (apb_cmd.penable && (psel & pready) != '0) begin
        for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
          if (psel[s] && apb_cmd.pwrite) begin
            mem[s][apb_cmd.paddr[5:2]] <= pwdata;
          end
        end
        pready <= '0;
      end else if (apb_cmd.penable) begin
        waits_left = waits_left - 1;
        if (waits_left == 0) begin
          pready <= psel;
        end
      end
    end
  end

  // One AHB transfer, returns once hready is back high
  task automatic run_transfer(input int slave, input int word, input logic write,
                              input logic seq, input ahb2apb_pkg::data_t wdata);
    @(posedge hclk20);
    hsel   <= 1'b1;
    haddr  <= word_addr(slave, word);
    htrans <= seq ? `AHB2APB_HTRANS_SEQ : `AHB2APB_HTRANS_NONSEQ;
    hwrite <= write;
    // Accept edge, data phase starts
    @(posedge hclk20);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;
    @(negedge hclk20);
    while (!hready) begin
      @(negedge hclk20);
    end
  endtask

  task automatic report_result();
    $display("Errors: %0d, transfers checked: %0d of %0d", errors, checked, N_TRANSFERS);
    if (errors == 0 && checked == N_TRANSFERS) begin
      $display("Simulation passed");
    end else begin
      if (checked != N_TRANSFERS) begin
        $display("Monitor did not see every transfer complete");
      end
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    logic [31:0] stim_rng;
    hreset_n20 = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hwrite     = 1'b0;
    hwdata     = '0;
    stim_rng   = SEED;
    repeat (RESET_CYCLES) @(posedge hclk20);
    hreset_n20 <= 1'b1;
    repeat (2) @(posedge hclk20);
    for (int n = 0; n < N_TRANSFERS; n++) begin
      stim_rng = xorshift32(stim_rng);
      run_transfer(int'(stim_rng[9:8]), int'(stim_rng[13:10]), stim_rng[16],
                   stim_rng[20], xorshift32(stim_rng));
    end
    repeat (2) @(posedge hclk20);
    report_result();
  end

  always @(posedge hclk20) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

// File: verilog/ahb2apb_bridge.sv
/* Top level of the AHB-Lite to APB bridge: front end, slave decoder
   and APB sequencer, write data passed straight through */

`timescale 1ns/10ps

module ahb2apb_bridge (
  input  logic                     hclk20,
  input  logic                     hreset_n20,
  // AHB-Lite slave port
  input  logic                     hsel,
  input  ahb2apb_pkg::addr_t       haddr,
  input  logic [1:0]               htrans,
  input  logic                     hwrite,
  input  ahb2apb_pkg::data_t       hwdata,
  output logic                     hready,
  output ahb2apb_pkg::data_t       hrdata,
  // APB master port
  output ahb2apb_pkg::apb_req_t    apb_cmd,
  output ahb2apb_pkg::slave_sel_t  psel,
  output ahb2apb_pkg::data_t       pwdata,
  input  ahb2apb_pkg::slave_sel_t  pready,
  input  ahb2apb_pkg::slave_data_t prdata
);

  logic                    accept;
  logic                    req_valid;
  logic                    done;
  ahb2apb_pkg::ahb_req_t   req;
  ahb2apb_pkg::slave_sel_t slave_sel;
  ahb2apb_pkg::data_t      rdata;

  // hwdata is held stable by the master while hready is low
  assign pwdata = hwdata;

  ahb_capture u_ahb_capture (
    .hclk20     (hclk20),
    .hreset_n20 (hreset_n20),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .done       (done),
    .rdata      (rdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .accept     (accept),
    .req        (req),
    .req_valid  (req_valid)
  );

  // Select registered on the accept edge, alongside req
  apb_decoder u_apb_decoder (
    .hclk20     (hclk20),
    .hreset_n20 (hreset_n20),
    .accept     (accept),
    .haddr      (haddr),
    .slave_sel  (slave_sel)
  );

  apb_sequencer u_apb_sequencer (
    .hclk20     (hclk20),
    .hreset_n20 (hreset_n20),
    .req        (req),
    .req_valid  (req_valid),
    .slave_sel  (slave_sel),
    .pready     (pready),
    .prdata     (prdata),
    .apb_cmd    (apb_cmd),
    .psel       (psel),
    .done       (done),
    .rdata      (rdata)
  );

endmodule

// File: verilog/ahb2apb_pkg.sv
/* Vector typedefs, request structs and APB state encoding for the bridge */

`include "ahb2apb_macros.svh"

package ahb2apb_pkg;

  // ----------------------------------------
  // Plain vectors
  // ----------------------------------------
  typedef logic [`AHB2APB_ADDR_W-1:0] addr_t;
  typedef logic [`AHB2APB_DATA_W-1:0] data_t;

  // One bit per APB slave
  typedef logic [`AHB2APB_SLAVES-1:0] slave_sel_t;

  // Read data from every slave, index = slave number
  typedef data_t [`AHB2APB_SLAVES-1:0] slave_data_t;

  // ----------------------------------------
  // Requests
  // ----------------------------------------
  // Address phase as captured on the AHB side
  typedef struct packed {
    addr_t addr;
    logic  write;
  } ahb_req_t;

  // Shared APB command lines
  typedef struct packed {
    addr_t paddr;
    logic  pwrite;
    logic  penable;
  } apb_req_t;

  // APB sequencer states, one-hot
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_t;

endpackage

// File: verilog/ahb_capture.sv
/* AHB slave front end: address and data phase tracking,
   request capture, hready and registered hrdata */

`timescale 1ns/10ps

`include "ahb2apb_macros.svh"

module ahb_capture (
  input  logic                  hclk20,
  input  logic                  hreset_n20,
  input  logic                  hsel,
  input  ahb2apb_pkg::addr_t    haddr,
  input  logic [1:0]            htrans,
  input  logic                  hwrite,
  input  logic                  done,
  input  ahb2apb_pkg::data_t    rdata,
  output logic                  hready,
  output ahb2apb_pkg::data_t    hrdata,
  output logic                  accept,
  output ahb2apb_pkg::ahb_req_t req,
  output logic                  req_valid
);

  logic addr_phase;
  logic data_phase;
  logic trans_valid;

  // NONSEQ or SEQ towards this slave
  assign trans_valid = hsel &&
                       ((htrans == `AHB2APB_HTRANS_NONSEQ) ||
                        (htrans == `AHB2APB_HTRANS_SEQ));

  // Only sampled while the bus is ready
  assign accept    = addr_phase && trans_valid;
  assign hready    = addr_phase;
  assign req_valid = data_phase;

  // ----------------------------------------
  // Phase flags
  // ----------------------------------------
  // Exactly one transfer in flight, hready low until done
  always_ff @(posedge hclk20 or negedge hreset_n20) begin
    if (!hreset_n20) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
    end else if (accept) begin
      addr_phase <= 1'b0;
      data_phase <= 1'b1;
    end else if (done) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
    end
  end

  // ----------------------------------------
  // Request and read data registers
  // ----------------------------------------
  always_ff @(posedge hclk20) begin
    if (accept) begin
      req.addr  <= haddr;
      req.write <= hwrite;
    end
  end

  // Read data valid once hready rises again
  always_ff @(posedge hclk20) begin
    if (done) begin
      hrdata <= rdata;
    end
  end

endmodule

// File: verilog/apb_decoder.sv
/* Registered one-hot APB slave select decoded from the AHB address */

`timescale 1ns/10ps

`include "ahb2apb_macros.svh"

module apb_decoder (
  input  logic                    hclk20,
  input  logic                    hreset_n20,
  input  logic                    accept,
  input  ahb2apb_pkg::addr_t      haddr,
  output ahb2apb_pkg::slave_sel_t slave_sel
);

  ahb2apb_pkg::slave_sel_t sel_next;

  // Window bounds for slave s, both inclusive
  function automatic ahb2apb_pkg::addr_t win_start(input int s);
    win_start = ahb2apb_pkg::addr_t'(`AHB2APB_BASE + s * `AHB2APB_WINDOW);
  endfunction

  function automatic ahb2apb_pkg::addr_t win_end(input int s);
    win_end = ahb2apb_pkg::addr_t'(`AHB2APB_BASE + (s + 1) * `AHB2APB_WINDOW - 1);
  endfunction

  // ----------------------------------------
  // Address compare
  // ----------------------------------------
  // Unmapped address gives an all-zero select
  always_comb begin
    sel_next = '0;
    for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
      sel_next[s] = (haddr >= win_start(s)) && (haddr <= win_end(s));
    end
  end

  // Captured on the same edge as the AHB request
  always_ff @(posedge hclk20 or negedge hreset_n20) begin
    if (!hreset_n20) begin
      slave_sel <= '0;
    end else if (accept) begin
      slave_sel <= sel_next;
    end
  end

endmodule

// File: verilog/apb_sequencer.sv
/* APB master sequencer: IDLE/SETUP/ACCESS state machine, psel and penable,
   pready and prdata muxing, completion back to the AHB side */

`timescale 1ns/10ps

`include "ahb2apb_macros.svh"

module apb_sequencer (
  input  logic                     hclk20,
  input  logic                     hreset_n20,
  input  ahb2apb_pkg::ahb_req_t    req,
  input  logic                     req_valid,
  input  ahb2apb_pkg::slave_sel_t  slave_sel,
  input  ahb2apb_pkg::slave_sel_t  pready,
  input  ahb2apb_pkg::slave_data_t prdata,
  output ahb2apb_pkg::apb_req_t    apb_cmd,
  output ahb2apb_pkg::slave_sel_t  psel,
  output logic                     done,
  output ahb2apb_pkg::data_t       rdata
);

  ahb2apb_pkg::apb_state_t state;
  ahb2apb_pkg::addr_t      paddr_q;
  logic                    pwrite_q;
  logic                    start;
  logic                    pready_sel;
  ahb2apb_pkg::data_t      prdata_sel;

  // ----------------------------------------
  // Slave return path
  // ----------------------------------------
  // Only the selected slave's pready counts
  assign pready_sel = |(psel & pready);

  // OR of gated read data, psel is one-hot
  always_comb begin
    prdata_sel = '0;
    for (int s = 0; s < `AHB2APB_SLAVES; s++) begin
      if (psel[s]) begin
        prdata_sel = prdata_sel | prdata[s];
      end
    end
  end

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  assign start = (state == ahb2apb_pkg::APB_IDLE) && req_valid;

  always_ff @(posedge hclk20 or negedge hreset_n20) begin
    if (!hreset_n20) begin
      state <= ahb2apb_pkg::APB_IDLE;
      psel  <= '0;
    end else begin
      case (state)
        ahb2apb_pkg::APB_IDLE: begin
          if (req_valid) begin
            state <= ahb2apb_pkg::APB_SETUP;
            psel  <= slave_sel;
          end
        end
        ahb2apb_pkg::APB_SETUP: begin
          state <= ahb2apb_pkg::APB_ACCESS;
        end
        ahb2apb_pkg::APB_ACCESS: begin
          // Wait states hold here
          if (pready_sel) begin
            state <= ahb2apb_pkg::APB_IDLE;
            psel  <= '0;
          end
        end
        default: begin
          state <= ahb2apb_pkg::APB_IDLE;
          psel  <= '0;
        end
      endcase
    end
  end

  // Address and direction, held through SETUP and ACCESS
  always_ff @(posedge hclk20) begin
    if (start) begin
      paddr_q  <= req.addr;
      pwrite_q <= req.write;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign apb_cmd.paddr   = paddr_q;
  assign apb_cmd.pwrite  = pwrite_q;
  assign apb_cmd.penable = (state == ahb2apb_pkg::APB_ACCESS);

  // One-cycle completion strobe, read data alongside
  assign done  = (state == ahb2apb_pkg::APB_ACCESS) && pready_sel;
  assign rdata = prdata_sel;

endmodule
